//--- list.f
+incdir+include
source/coreTypes.sv
source/instrMem.sv
source/hazardUnit.sv
source/instrFetch.sv
source/instrDecode.sv
source/execUnit.sv
source/resultStage.sv
source/coreTop.sv
verif/coreTb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and set the exit status from its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module coreTb -f list.f -o coreSim || exit 1
simOut=$(./obj_dir/coreSim 2>&1)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx 'Done: no errors' && exit 0 || exit 1

//--- source/coreTop.sv
// Core top: fetch, instruction memory, decode, execute and result stages
`timescale 1ns/1ps

module coreTop (
   input  logic                                clk,
   input  logic                                arstN,
   input  logic                                run,
   input  logic                                loadEn,
   input  logic [coreTypes::imemAddrWidth-1:0] loadAddr,
   input  logic [coreTypes::instrWidth-1:0]    loadData,
   output coreTypes::wbT                       wb,
   output logic                                halted,
   output logic                                err
);

   coreTypes::fetchOutT  fdBus;
   coreTypes::decodeOutT dxBus;
   coreTypes::execOutT   xrBus;
   logic redirect;
   logic [coreTypes::dataWidth-1:0] redirectPc;
   logic [coreTypes::imemAddrWidth-1:0] imemAddr;
   logic [coreTypes::instrWidth-1:0] imemData;

   instrFetch u_instrFetch (
      .clk, .arstN, .run, .redirect, .redirectPc, .halted,
      .dxEntry  (dxBus),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .fdOut    (fdBus)
   );

   instrMem u_instrMem (
      .clk, .loadEn, .loadAddr, .loadData,
      .addr  (imemAddr),
      .instr (imemData)
   );

   instrDecode u_instrDecode (.clk, .arstN, .fdIn(fdBus), .wbIn(wb), .dxOut(dxBus));

   execUnit u_execUnit (.clk, .arstN, .dxIn(dxBus), .xrOut(xrBus));

   resultStage u_resultStage (
      .clk, .arstN, .xrIn(xrBus), .wb, .redirect, .redirectPc, .halted, .err
   );

endmodule

//--- source/coreTypes.sv
// Core package: sizes, opcode enum, instruction field layout and pipeline records
package coreTypes;

   localparam int dataWidth     = 16;
   localparam int instrWidth    = 16;
   localparam int regCount      = 8;
   localparam int regIdxWidth   = 3;
   localparam int imemDepth     = 256;
   localparam int imemAddrWidth = 8;
   localparam int opcodeWidth   = 4;

   // Instruction layout, lsb of each field
   localparam int opcodeLsb    = 12;
   localparam int rdLsb        = 9;
   localparam int rsLsb        = 6;
   localparam int rtLsb        = 3;
   localparam int addiImmWidth = 6;  // Low bits, signed
   localparam int lbiImmWidth  = 8;  // Low bits after rd, signed
   localparam int brOffWidth   = 6;  // Word offset below the rs field, signed

   typedef enum logic [opcodeWidth-1:0] {
      opNop  = 4'h0,
      opAdd  = 4'h1,
      opSub  = 4'h2,
      opAnd  = 4'h3,
      opXor  = 4'h4,
      opAddi = 4'h5,
      opLbi  = 4'h6,
      opBeqz = 4'h7,
      opHalt = 4'h8
   } opcodeT;  // Codes 9 to 15 are illegal

   typedef struct packed {
      logic                  valid;
      logic [instrWidth-1:0] instr;
      logic [dataWidth-1:0]  pcInc;
   } fetchOutT;

   typedef struct packed {
      logic                   valid;
      opcodeT                 opcode;
      logic [regIdxWidth-1:0] rd;
      logic                   wrEn;
      logic [dataWidth-1:0]   opA;
      logic [dataWidth-1:0]   opB;
      logic [dataWidth-1:0]   imm;
      logic [dataWidth-1:0]   pcInc;
   } decodeOutT;

   typedef struct packed {
      logic                   valid;
      opcodeT                 opcode;
      logic [regIdxWidth-1:0] rd;
      logic                   wrEn;
      logic [dataWidth-1:0]   result;    // Fall-through PC for BEQZ
      logic                   brTaken;
      logic [dataWidth-1:0]   brTarget;
      logic                   illegal;
   } execOutT;

   typedef struct packed {
      logic                   valid;
      logic                   wrEn;
      logic [regIdxWidth-1:0] rd;
      logic [dataWidth-1:0]   data;
   } wbT;

   // Ops that write rd
   function automatic logic isWriter(opcodeT op);
      case (op)
         opAdd, opSub, opAnd, opXor, opAddi, opLbi: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

endpackage

//--- source/execUnit.sv
// Execute stage: ALU, branch condition and target, execute/result register
`timescale 1ns/1ps

module execUnit (
   input  logic                 clk,
   input  logic                 arstN,
   input  coreTypes::decodeOutT dxIn,
   output coreTypes::execOutT   xrOut
);

   logic [coreTypes::dataWidth-1:0] result;
   logic [coreTypes::dataWidth-1:0] brTarget;
   logic brTaken;
   logic illegal;

   always_comb begin
      result  = '0;
      illegal = 1'b0;
      case (dxIn.opcode)
         coreTypes::opNop, coreTypes::opHalt: result = '0;
         coreTypes::opAdd:  result = dxIn.opA + dxIn.opB;
         coreTypes::opSub:  result = dxIn.opA - dxIn.opB;
         coreTypes::opAnd:  result = dxIn.opA & dxIn.opB;
         coreTypes::opXor:  result = dxIn.opA ^ dxIn.opB;
         coreTypes::opAddi: result = dxIn.opA + dxIn.imm;
         coreTypes::opLbi:  result = dxIn.imm;
         coreTypes::opBeqz: result = dxIn.pcInc;  // Not-taken path
         default:           illegal = 1'b1;
      endcase
   end

   assign brTaken  = (dxIn.opcode == coreTypes::opBeqz) && (dxIn.opA == '0);
   assign brTarget = dxIn.pcInc + {dxIn.imm[coreTypes::dataWidth-2:0], 1'b0};  // Offset in words

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         xrOut <= '0;
      end else begin
         xrOut.valid    <= dxIn.valid;
         xrOut.opcode   <= dxIn.opcode;
         xrOut.rd       <= dxIn.rd;
         xrOut.wrEn     <= dxIn.wrEn & ~illegal;
         xrOut.result   <= result;
         xrOut.brTaken  <= brTaken;
         xrOut.brTarget <= brTarget;
         xrOut.illegal  <= illegal;
      end
   end

endmodule

//--- source/hazardUnit.sv
// Hazard detection: source registers of the fetched word against in-flight writers and branches
`timescale 1ns/1ps

module hazardUnit (
   input  logic [coreTypes::instrWidth-1:0] fetchInstr,
   input  coreTypes::fetchOutT              fdEntry,
   input  coreTypes::decodeOutT             dxEntry,
   output logic                             stall,
   output logic                             isBranch
);

   coreTypes::opcodeT fetchOp;
   coreTypes::opcodeT fdOp;
   logic [coreTypes::regIdxWidth-1:0] fetchRs;
   logic [coreTypes::regIdxWidth-1:0] fetchRt;
   logic [coreTypes::regIdxWidth-1:0] fdRd;
   logic useRs;
   logic useRt;
   logic fdWr;
   logic dxWr;
   logic rsHit;
   logic rtHit;
   logic branchInFlight;

   assign fetchOp = coreTypes::opcodeT'(fetchInstr[coreTypes::opcodeLsb +: coreTypes::opcodeWidth]);
   assign fetchRs = fetchInstr[coreTypes::rsLsb +: coreTypes::regIdxWidth];
   assign fetchRt = fetchInstr[coreTypes::rtLsb +: coreTypes::regIdxWidth];
   assign fdOp    = coreTypes::opcodeT'(fdEntry.instr[coreTypes::opcodeLsb +: coreTypes::opcodeWidth]);
   assign fdRd    = fdEntry.instr[coreTypes::rdLsb +: coreTypes::regIdxWidth];

   // Which sources the fetched word reads
   always_comb begin
      useRs = 1'b0;
      useRt = 1'b0;
      case (fetchOp)
         coreTypes::opAdd, coreTypes::opSub, coreTypes::opAnd, coreTypes::opXor: begin
            useRs = 1'b1;
            useRt = 1'b1;
         end
         coreTypes::opAddi, coreTypes::opBeqz: useRs = 1'b1;
         default: ;
      endcase
   end

   assign fdWr = fdEntry.valid & coreTypes::isWriter(fdOp);  // Decode slot not yet decoded
   assign dxWr = dxEntry.valid & dxEntry.wrEn;

   assign rsHit = useRs & ((fdWr & (fdRd == fetchRs)) | (dxWr & (dxEntry.rd == fetchRs)));
   assign rtHit = useRt & ((fdWr & (fdRd == fetchRt)) | (dxWr & (dxEntry.rd == fetchRt)));

   assign branchInFlight = (fdEntry.valid & (fdOp == coreTypes::opBeqz))
                         | (dxEntry.valid & (dxEntry.opcode == coreTypes::opBeqz));

   assign stall    = rsHit | rtHit | branchInFlight;
   assign isBranch = fetchOp == coreTypes::opBeqz;

endmodule

//--- source/instrDecode.sv
// Decode stage: field split, immediate extension, register file and decode/execute register
`timescale 1ns/1ps

module instrDecode (
   input  logic                 clk,
   input  logic                 arstN,
   input  coreTypes::fetchOutT  fdIn,
   input  coreTypes::wbT        wbIn,
   output coreTypes::decodeOutT dxOut
);

   localparam int addiPad = coreTypes::dataWidth - coreTypes::addiImmWidth;
   localparam int lbiPad  = coreTypes::dataWidth - coreTypes::lbiImmWidth;
   localparam int brPad   = coreTypes::dataWidth - coreTypes::brOffWidth;

   logic [coreTypes::dataWidth-1:0] regFile [coreTypes::regCount];

   coreTypes::opcodeT op;
   logic [coreTypes::regIdxWidth-1:0] rd;
   logic [coreTypes::regIdxWidth-1:0] rs;
   logic [coreTypes::regIdxWidth-1:0] rt;
   logic [coreTypes::dataWidth-1:0] rsData;
   logic [coreTypes::dataWidth-1:0] rtData;
   logic [coreTypes::dataWidth-1:0] imm;

   assign op = coreTypes::opcodeT'(fdIn.instr[coreTypes::opcodeLsb +: coreTypes::opcodeWidth]);
   assign rd = fdIn.instr[coreTypes::rdLsb +: coreTypes::regIdxWidth];
   assign rs = fdIn.instr[coreTypes::rsLsb +: coreTypes::regIdxWidth];
   assign rt = fdIn.instr[coreTypes::rtLsb +: coreTypes::regIdxWidth];

   // Sign-extended immediate per format
   always_comb begin
      case (op)
         coreTypes::opAddi: begin
            imm = {{addiPad{fdIn.instr[coreTypes::addiImmWidth-1]}},
                   fdIn.instr[coreTypes::addiImmWidth-1:0]};
         end
         coreTypes::opLbi: begin
            imm = {{lbiPad{fdIn.instr[coreTypes::lbiImmWidth-1]}},
                   fdIn.instr[coreTypes::lbiImmWidth-1:0]};
         end
         coreTypes::opBeqz: begin
            imm = {{brPad{fdIn.instr[coreTypes::brOffWidth-1]}},
                   fdIn.instr[coreTypes::brOffWidth-1:0]};  // Word offset
         end
         default: imm = '0;
      endcase
   end

   // Commit writes at the edge ending the result cycle, r0 included
   always_ff @(posedge clk) begin
      if (wbIn.valid && wbIn.wrEn) begin
         regFile[wbIn.rd] <= wbIn.data;
      end
   end

   // Two read ports, no bypass needed since hazards stall in fetch
   assign rsData = regFile[rs];
   assign rtData = regFile[rt];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         dxOut <= '0;
      end else begin
         dxOut.valid  <= fdIn.valid;
         dxOut.opcode <= op;
         dxOut.rd     <= rd;
         dxOut.wrEn   <= coreTypes::isWriter(op);
         dxOut.opA    <= rsData;
         dxOut.opB    <= rtData;
         dxOut.imm    <= imm;
         dxOut.pcInc  <= fdIn.pcInc;
      end
   end

endmodule

//--- source/instrFetch.sv
// Fetch stage: PC, incrementer, redirect select, bubble insertion and fetch/decode register
`timescale 1ns/1ps

module instrFetch (
   input  logic                                clk,
   input  logic                                arstN,
   input  logic                                run,
   input  logic                                redirect,
   input  logic [coreTypes::dataWidth-1:0]     redirectPc,
   input  logic                                halted,
   input  coreTypes::decodeOutT                dxEntry,
   output logic [coreTypes::imemAddrWidth-1:0] imemAddr,
   input  logic [coreTypes::instrWidth-1:0]    imemData,
   output coreTypes::fetchOutT                 fdOut
);

   logic [coreTypes::dataWidth-1:0] pc;
   logic [coreTypes::dataWidth-1:0] pcInc;
   logic waitBranch;  // BEQZ passed on, not yet resolved
   logic hzStall;
   logic isBranch;
   logic issue;

   hazardUnit u_hazardUnit (
      .fetchInstr (imemData),
      .fdEntry    (fdOut),
      .dxEntry    (dxEntry),
      .stall      (hzStall),
      .isBranch   (isBranch)
   );

   assign imemAddr = pc[coreTypes::imemAddrWidth:1];  // Byte PC to word address
   assign pcInc    = pc + coreTypes::dataWidth'(2);

   // A real instruction enters decode only when nothing holds fetch
   assign issue = run & ~halted & ~waitBranch & ~hzStall;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc         <= '0;
         waitBranch <= 1'b0;
      end else if (!run) begin
         pc         <= '0;  // Loader phase, start again from zero
         waitBranch <= 1'b0;
      end else begin
         if (redirect) begin
            pc <= redirectPc;  // Target or fall-through from result stage
         end else if (issue) begin
            pc <= pcInc;
         end

         if (redirect) begin
            waitBranch <= 1'b0;
         end else if (issue && isBranch) begin
            waitBranch <= 1'b1;
         end
      end
   end

   // Fetch/decode register, bubble when not issuing
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         fdOut <= '0;
      end else if (issue) begin
         fdOut.valid <= 1'b1;
         fdOut.instr <= imemData;
         fdOut.pcInc <= pcInc;
      end else begin
         fdOut.valid <= 1'b0;
      end
   end

endmodule

//--- source/instrMem.sv
// Instruction RAM: combinational word read, clocked loader write
`timescale 1ns/1ps

module instrMem (
   input  logic                                 clk,
   input  logic                                 loadEn,
   input  logic [coreTypes::imemAddrWidth-1:0]  loadAddr,
   input  logic [coreTypes::instrWidth-1:0]     loadData,
   input  logic [coreTypes::imemAddrWidth-1:0]  addr,
   output logic [coreTypes::instrWidth-1:0]     instr
);

   logic [coreTypes::instrWidth-1:0] mem [coreTypes::imemDepth];

   // Loader port, used only while run is low
   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end
   end

   assign instr = mem[addr];  // Async read for fetch

endmodule

//--- source/resultStage.sv
// Result stage: commit broadcast, branch redirect, halt and error latches
`timescale 1ns/1ps

module resultStage (
   input  logic                            clk,
   input  logic                            arstN,
   input  coreTypes::execOutT              xrIn,
   output coreTypes::wbT                   wb,
   output logic                            redirect,
   output logic [coreTypes::dataWidth-1:0] redirectPc,
   output logic                            halted,
   output logic                            err
);

   logic commit;

   assign commit = xrIn.valid & ~halted;  // Younger ops behind HALT retire silently

   always_comb begin
      wb.valid = commit;
      wb.wrEn  = commit & xrIn.wrEn & ~xrIn.illegal;
      wb.rd    = xrIn.rd;
      wb.data  = xrIn.result;
   end

   assign redirect   = commit & (xrIn.opcode == coreTypes::opBeqz);
   assign redirectPc = xrIn.brTaken ? xrIn.brTarget : xrIn.result;

   // Sticky until reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         if (commit && (xrIn.opcode == coreTypes::opHalt || xrIn.illegal)) begin
            halted <= 1'b1;
         end
         if (commit && xrIn.illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

//--- include/progTable.svh
// Test programs with their expected commit traces and final error flags
`ifndef PROG_TABLE_SVH
`define PROG_TABLE_SVH

localparam int progCount  = 4;
localparam int progMaxLen = 10;
localparam int traceMaxLen = 7;

// Words per program with a NOP tail
localparam logic [15:0] progWords [progCount][progMaxLen] = '{
   // LBI, ALU ops and ADDI
   '{16'h6205, 16'h64FD, 16'h1650, 16'h2850, 16'h3A50,
     16'h4C50, 16'h5EFF, 16'h8000, 16'h0000, 16'h0000},
   // Back-to-back dependent chain
   '{16'h6201, 16'h5242, 16'h1448, 16'h2688, 16'h40D0,
     16'h501F, 16'h8000, 16'h0000, 16'h0000, 16'h0000},
   // BEQZ taken, BEQZ not taken, code after HALT
   '{16'h6200, 16'h7042, 16'h6411, 16'h6622, 16'h6807,
     16'h7101, 16'h593E, 16'h8000, 16'h6A01, 16'h0000},
   // Illegal opcode
   '{16'h6CFF, 16'h0000, 16'hF000, 16'h6E01, 16'h0000,
     16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

localparam int progLen [progCount] = '{8, 7, 9, 4};

// Register writes in commit order as {index, value}
localparam logic [18:0] progTrace [progCount][traceMaxLen] = '{
   '{{3'd1, 16'h0005}, {3'd2, 16'hFFFD}, {3'd3, 16'h0002}, {3'd4, 16'h0008},
     {3'd5, 16'h0005}, {3'd6, 16'hFFF8}, {3'd7, 16'h0001}},
   '{{3'd1, 16'h0001}, {3'd1, 16'h0003}, {3'd2, 16'h0006}, {3'd3, 16'h0003},
     {3'd0, 16'h0005}, {3'd0, 16'h0024}, {3'd0, 16'h0000}},
   '{{3'd1, 16'h0000}, {3'd4, 16'h0007}, {3'd4, 16'h0005}, {3'd0, 16'h0000},
     {3'd0, 16'h0000}, {3'd0, 16'h0000}, {3'd0, 16'h0000}},
   '{{3'd6, 16'hFFFF}, {3'd0, 16'h0000}, {3'd0, 16'h0000}, {3'd0, 16'h0000},
     {3'd0, 16'h0000}, {3'd0, 16'h0000}, {3'd0, 16'h0000}}
};

localparam int progTraceLen [progCount] = '{7, 6, 3, 1};

localparam logic progErr [progCount] = '{1'b0, 1'b0, 1'b0, 1'b1};

`endif

//--- verif/coreTb.sv
// Core testbench with clock, reset, loader, ISA reference model, table-driven checks and watchdog
`timescale 1ns/1ps

module coreTb;

   `include "progTable.svh"

   localparam int halfPeriod    = 2;
   localparam int resetCycles   = 10;
   localparam int drainCycles   = 8;   // Cycles watched after halt
   localparam int cyclesPerWord = 40;
   localparam int genBody       = 12;  // Random ALU and ADDI ops
   localparam int genLen        = coreTypes::regCount + genBody + 1;

   logic clk;
   logic arstN;
   logic run;
   logic loadEn;
   logic [coreTypes::imemAddrWidth-1:0] loadAddr;
   logic [coreTypes::instrWidth-1:0] loadData;
   coreTypes::wbT wb;
   logic halted;
   logic err;

   logic [15:0] progImage [coreTypes::imemDepth];  // Program under test
   int progSize;
   logic [2:0] modelIdx [$];   // Expected commits from the model
   logic [15:0] modelVal [$];
   logic modelHalted;
   logic modelErr;

   coreTop u_coreTop (.clk, .arstN, .run, .loadEn, .loadAddr, .loadData, .wb, .halted, .err);

   always #halfPeriod clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "run stopped");
   endtask

   task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "first mismatch");
      end
   endtask

   task automatic stageTable(input int p);
      progSize = progLen[p];
      for (int i = 0; i < progSize; i++) begin
         progImage[i] = progWords[p][i];
      end
   endtask

   // LBI into every register first, then random ops on random registers
   task automatic buildRandom();
      logic [31:0] r;
      logic [3:0] op;
      progSize = genLen;
      for (int i = 0; i < genLen - 1; i++) begin
         r = $urandom;
         op = 4'($urandom_range(1, 5));
         if (i < coreTypes::regCount) begin
            progImage[i] = {4'h6, 3'(i), 1'b0, r[7:0]};
         end else if (op == 4'h5) begin
            progImage[i] = {op, r[2:0], r[5:3], r[14:9]};  // ADDI
         end else begin
            progImage[i] = {op, r[2:0], r[5:3], r[8:6], 3'b000};
         end
      end
      progImage[genLen-1] = 16'h8000;  // HALT
   endtask

   // ISA semantics over progImage with a byte PC stepping by two
   task automatic runModel();
      logic [15:0] regs [coreTypes::regCount];
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] res;
      coreTypes::opcodeT op;
      int steps;
      modelIdx.delete();
      modelVal.delete();
      modelHalted = 1'b0;
      modelErr = 1'b0;
      pc = '0;
      steps = 0;
      while (!modelHalted) begin
         w = progImage[pc[8:1]];
         op = coreTypes::opcodeT'(w[15:12]);
         pc = pc + 16'd2;
         res = '0;
         case (op)
            coreTypes::opAdd:  res = regs[w[8:6]] + regs[w[5:3]];
            coreTypes::opSub:  res = regs[w[8:6]] - regs[w[5:3]];
            coreTypes::opAnd:  res = regs[w[8:6]] & regs[w[5:3]];
            coreTypes::opXor:  res = regs[w[8:6]] ^ regs[w[5:3]];
            coreTypes::opAddi: res = regs[w[8:6]] + {{10{w[5]}}, w[5:0]};
            coreTypes::opLbi:  res = {{8{w[7]}}, w[7:0]};
            coreTypes::opBeqz: begin
               if (regs[w[8:6]] == 16'd0) begin
                  pc = pc + {{9{w[5]}}, w[5:0], 1'b0};  // Word offset from next PC
               end
            end
            coreTypes::opNop:  ;
            coreTypes::opHalt: modelHalted = 1'b1;
            default: begin
               modelHalted = 1'b1;
               modelErr = 1'b1;
            end
         endcase
         if (op inside {coreTypes::opAdd, coreTypes::opSub, coreTypes::opAnd,
                        coreTypes::opXor, coreTypes::opAddi, coreTypes::opLbi}) begin
            regs[w[11:9]] = res;
            modelIdx.push_back(w[11:9]);
            modelVal.push_back(res);
         end
         steps++;
         if (steps > 4 * coreTypes::imemDepth) begin
            failRun("Reference model never reached HALT");
         end
      end
   endtask

   // Model against the expected trace in the table
   task automatic checkTable(input int p);
      checkEq("model trace length", 32'(modelIdx.size()), 32'(progTraceLen[p]));
      foreach (modelIdx[i]) begin
         checkEq("model trace entry", {13'd0, modelIdx[i], modelVal[i]}, 32'(progTrace[p][i]));
      end
      checkEq("model err", 32'(modelErr), 32'(progErr[p]));
   endtask

   task automatic runProgram(input int p);
      int commits;
      int cycles;
      @(posedge clk);
      arstN <= 1'b0;
      run <= 1'b0;
      loadEn <= 1'b0;
      repeat (resetCycles) @(posedge clk);
      arstN <= 1'b1;
      for (int i = 0; i < progSize; i++) begin
         @(posedge clk);
         loadEn <= 1'b1;
         loadAddr <= 8'(i);
         loadData <= progImage[i];
         @(negedge clk);
         checkEq("wb.valid while run low", 32'(wb.valid), 32'd0);
         checkEq("halted while run low", 32'(halted), 32'd0);
         checkEq("err while run low", 32'(err), 32'd0);
      end
      @(posedge clk);
      loadEn <= 1'b0;
      run <= 1'b1;  // Last word is written on this edge
      commits = 0;
      cycles = 0;
      while (!halted) begin
         @(negedge clk);
         if (wb.valid && wb.wrEn) begin
            if (commits >= modelIdx.size()) begin
               failRun($sformatf("Program %0d wrote a register beyond its expected trace", p));
            end
            checkEq("commit rd", 32'(wb.rd), 32'(modelIdx[commits]));
            checkEq("commit data", 32'(wb.data), 32'(modelVal[commits]));
            commits++;
         end
         cycles++;
         if (cycles > cyclesPerWord * progSize) begin
            failRun($sformatf("Program %0d did not halt within %0d cycles", p, cycles));
         end
      end
      repeat (drainCycles) begin
         @(negedge clk);
         checkEq("wb.valid after halt", 32'(wb.valid), 32'd0);
      end
      checkEq("commit count", 32'(commits), 32'(modelIdx.size()));
      checkEq("halted", 32'(halted), 32'(modelHalted));
      checkEq("err", 32'(err), 32'(modelErr));
   endtask

   // Limit from table length plus the generated program
   initial begin
      int words;
      words = genLen;
      for (int p = 0; p < progCount; p++) begin
         words += progLen[p];
      end
      repeat (words * cyclesPerWord + (progCount + 1) * (resetCycles + drainCycles + 2))
         @(posedge clk);
      failRun($sformatf("Watchdog expired at %0t ns, the simulation hung", $time));
   end

   initial begin
      clk = 1'b0;
      arstN = 1'b0;
      run = 1'b0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadData = '0;
      void'($urandom(32'hd13a));
      for (int p = 0; p < progCount; p++) begin
         stageTable(p);
         runModel();
         checkTable(p);
         runProgram(p);
      end
      buildRandom();
      runModel();
      runProgram(progCount);  // Generated program
      $display("Done: no errors");
      $finish;
   end

endmodule
